//--- design/cache_data_config.svh
`ifndef CACHE_DATA_CONFIG_SVH
`define CACHE_DATA_CONFIG_SVH

// geometry of the two-way data array

// width of one data word and of one bank
`define CD_WORD_W 32

// each line is split into this many word-wide banks
`define CD_LINE_WORDS 16

`define CD_SETS 64    // entries per bank, one per set

// number of ways in the cache
`define CD_WAYS 2

`define CD_TAG_W 20   // tag bits above the index

`endif

//--- design/cache_data_pkg.sv
`include "cache_data_config.svh"

package cache_data_pkg;

    localparam int BYTES_PER_WORD = `CD_WORD_W / 8;
    localparam int INDEX_W        = $clog2(`CD_SETS);
    localparam int WORD_SEL_W     = $clog2(`CD_LINE_WORDS);
    localparam int BYTE_OFF_W     = $clog2(BYTES_PER_WORD);

    typedef logic [`CD_WORD_W-1:0] word_t;

    // word 0 of the line sits in the low bits
    typedef word_t [`CD_LINE_WORDS-1:0] line_t;

    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [WORD_SEL_W-1:0]     word_sel_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // one-hot hit vector, bit 0 is way 0
    typedef logic [`CD_WAYS-1:0] way_mask_t;

    // tag, set index, word within line, byte within word
    typedef struct packed {
        logic [`CD_TAG_W-1:0]  tag;
        index_t                index;
        word_sel_t             word;
        logic [BYTE_OFF_W-1:0] byte_off;
    } addr_t;

    // word request from the core, we of zero is a read
    typedef struct packed {
        logic     en;
        byte_en_t we;
        addr_t    addr;
        word_t    wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } refill_t;

endpackage

//--- design/data_bank.sv
`timescale 1ns/100ps
`include "cache_data_config.svh"

module data_bank (
    input  logic                     clk,
    input  logic                     en,
    input  cache_data_pkg::byte_en_t we,
    input  cache_data_pkg::index_t   addr,
    input  cache_data_pkg::word_t    din,
    output cache_data_pkg::word_t    dout
);
    import cache_data_pkg::*;

    word_t mem [`CD_SETS];

    // read-first port: dout gets the contents from before this write
    always_ff @(posedge clk) begin
        if (en) begin
            dout <= mem[addr];
        end
    end

    // each byte lane writes on its own enable
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= din[b*8 +: 8];
                end
            end
        end
    end

    // dout keeps its last value while en is low, so a line read
    // stays visible until the next access to this bank

endmodule

//--- design/data_way.sv
`timescale 1ns/100ps
`include "cache_data_config.svh"

module data_way (
    input  logic                     clk,
    input  cache_data_pkg::cpu_req_t req,
    input  logic                     hit,
    input  logic                     refill_we,
    input  logic                     line_rd,
    input  cache_data_pkg::line_t    refill_line,
    output cache_data_pkg::line_t    rd_line
);
    import cache_data_pkg::*;

    logic [`CD_LINE_WORDS-1:0] bank_sel;
    logic                      word_hit;
    index_t                    set_index;

    // one-hot decode of the word number, one bit per bank
    always_comb begin
        bank_sel = '0;
        bank_sel[req.addr.word] = 1'b1;
    end

    assign word_hit  = req.en & hit;     // word access aimed at this way
    assign set_index = req.addr.index;   // line commands use the same index

    for (genvar i = 0; i < `CD_LINE_WORDS; i++) begin : g_bank
        logic     bank_en;
        byte_en_t bank_we;
        word_t    bank_din;

        // a line command opens every bank of the way
        assign bank_en = line_rd | (word_hit & bank_sel[i]);

        // refill writes the whole word, a plain line read writes nothing
        always_comb begin
            if (refill_we) begin
                bank_we = '1;
            end else if (line_rd) begin
                bank_we = '0;
            end else begin
                bank_we = req.we;
            end
        end

        assign bank_din = refill_we ? refill_line[i] : req.wdata;

        data_bank data_bank_inst (
            .clk  (clk),
            .en   (bank_en),
            .we   (bank_we),
            .addr (set_index),
            .din  (bank_din),
            .dout (rd_line[i])
        );
    end

    // a word access enables only one bank, so the other words of rd_line
    // hold whatever they last read and only the selected word is fresh

endmodule

//--- design/read_select.sv
`timescale 1ns/100ps
`include "cache_data_config.svh"

module read_select (
    input  logic                      clk,
    input  logic                      reset,
    input  cache_data_pkg::way_mask_t hit,
    input  logic                      lru,
    input  cache_data_pkg::word_sel_t word,
    input  cache_data_pkg::line_t     way0_line,
    input  cache_data_pkg::line_t     way1_line,
    output cache_data_pkg::word_t     rdata,
    output cache_data_pkg::line_t     victim_line
);
    import cache_data_pkg::*;

    way_mask_t hit_r;
    logic      lru_r;
    word_sel_t word_r;
    word_t     way0_word;
    word_t     way1_word;

    // these line up with the bank outputs, which come one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_r  <= '0;
            lru_r  <= 1'b0;
            word_r <= '0;
        end else begin
            hit_r  <= hit;
            lru_r  <= lru;
            word_r <= word;
        end
    end

    assign way0_word = way0_line[word_r];
    assign way1_word = way1_line[word_r];

    // hit is one-hot or zero, a miss reads as zero
    always_comb begin
        if (hit_r[0]) begin
            rdata = way0_word;
        end else if (hit_r[1]) begin
            rdata = way1_word;
        end else begin
            rdata = '0;
        end
    end

    // the victim is the line of the way that lru named
    assign victim_line = lru_r ? way1_line : way0_line;

endmodule

//--- design/cache_data_top.sv
`timescale 1ns/100ps
`include "cache_data_config.svh"

module cache_data_top (
    input  logic                      clk,
    input  logic                      reset,
    input  cache_data_pkg::cpu_req_t  cpu_req,
    input  cache_data_pkg::way_mask_t hit,
    input  logic                      lru,
    input  logic                      write_back,
    input  cache_data_pkg::refill_t   refill,
    output cache_data_pkg::word_t     rdata,
    output cache_data_pkg::line_t     victim_line
);
    import cache_data_pkg::*;

    logic                line_rd;
    logic [`CD_WAYS-1:0] refill_we;
    line_t               way_line [`CD_WAYS];
    word_sel_t           req_word;

    // refill and write-back both read out every bank of both ways
    assign line_rd = refill.valid | write_back;

    assign req_word = cpu_req.addr.word;

    for (genvar w = 0; w < `CD_WAYS; w++) begin : g_way
        // only the way named by lru takes the refill line
        assign refill_we[w] = refill.valid & (lru == 1'(w));

        data_way data_way_inst (
            .clk         (clk),
            .req         (cpu_req),
            .hit         (hit[w]),
            .refill_we   (refill_we[w]),
            .line_rd     (line_rd),
            .refill_line (refill.line),
            .rd_line     (way_line[w])
        );
    end

    // word and victim selection happen after the bank read
    read_select read_select_inst (
        .clk         (clk),
        .reset       (reset),
        .hit         (hit),
        .lru         (lru),
        .word        (req_word),
        .way0_line   (way_line[0]),
        .way1_line   (way_line[1]),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

    // a refill and a write-back never write the way that is not
    // selected, since line_rd forces its byte enables to zero

endmodule

//--- bench/tb_cache_data.sv
`timescale 1ns/100ps
`include "cache_data_config.svh"

module tb_cache_data;
    import cache_data_pkg::*;

    localparam int NUM_READS   = 500;
    localparam int NUM_WRITES  = 600;   // each write is followed by a read of the same word
    localparam int NUM_NO_HIT  = 250;   // each miss is followed by a read of the same word
    localparam int NUM_WB      = 300;
    localparam int NUM_VICTIMS = 200;   // each refill is followed by a read of the new line

    // about 3000 commands at one per cycle, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk;
    logic      reset;
    cpu_req_t  cpu_req;
    way_mask_t hit;
    logic      lru;
    logic      write_back;
    refill_t   refill;
    word_t     rdata;
    line_t     victim_line;

    word_t model [`CD_WAYS][`CD_SETS][`CD_LINE_WORDS];
    bit    filled [`CD_WAYS][`CD_SETS];

    // expected results of the last command, which show up one cycle later
    bit    pend_valid;
    bit    pend_check_line;
    string pend_name;
    word_t pend_rdata;
    line_t pend_victim;

    int cycle_count = 0;

    cache_data_top cache_data_top_inst (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .hit         (hit),
        .lru         (lru),
        .write_back  (write_back),
        .refill      (refill),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [511:0] expected,
                               input logic [511:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    function automatic line_t model_line(input int way, input int set);
        line_t l;
        for (int i = 0; i < `CD_LINE_WORDS; i++) begin
            l[i] = model[way][set][i];
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < `CD_LINE_WORDS; i++) begin
            l[i] = $urandom;
        end
        return l;
    endfunction

    function automatic cpu_req_t make_req(input logic en, input byte_en_t we, input int set,
                                          input int word, input word_t wdata);
        cpu_req_t r;
        r.en            = en;
        r.we            = we;
        r.addr.tag      = $urandom;   // tag and byte offset play no part in the data array
        r.addr.index    = index_t'(set);
        r.addr.word     = word_sel_t'(word);
        r.addr.byte_off = $urandom;
        r.wdata         = wdata;
        return r;
    endfunction

    task automatic check_pending();
        if (pend_valid) begin
            check_value({pend_name, " rdata"}, pend_rdata, rdata);
            if (pend_check_line) begin
                check_value({pend_name, " victim_line"}, pend_victim, victim_line);
            end
        end
    endtask

    // drives one command, checks the one before it and updates the model
    task automatic apply_cmd(input string name, input cpu_req_t req, input way_mask_t h,
                             input logic l, input logic wb, input refill_t rf);
        int    set;
        int    word;
        int    way;
        word_t old;
        @(posedge clk);
        cpu_req    <= req;
        hit        <= h;
        lru        <= l;
        write_back <= wb;
        refill     <= rf;
        @(negedge clk);
        check_pending();
        set  = req.addr.index;
        word = req.addr.word;
        way  = h[1] ? 1 : 0;
        // banks are read-first, so a hit returns the word from before this command
        old  = (h == '0) ? word_t'(0) : model[way][set][word];
        pend_valid      = 1'b1;
        pend_name       = name;
        pend_rdata      = old;
        pend_check_line = 1'b0;
        if (rf.valid) begin
            pend_check_line = filled[l][set];   // an empty set has no defined victim
            pend_victim     = model_line(l, set);
            for (int i = 0; i < `CD_LINE_WORDS; i++) begin
                model[l][set][i] = rf.line[i];
            end
            filled[l][set] = 1'b1;
        end else if (wb) begin
            pend_check_line = 1'b1;
            pend_victim     = model_line(l, set);
        end else if (req.en && h != '0) begin
            for (int b = 0; b < `CD_WORD_W / 8; b++) begin
                if (req.we[b]) begin
                    model[way][set][word][b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end
    endtask

    initial begin
        int       way;
        int       set;
        int       word;
        logic     l;
        byte_en_t we;
        refill_t  rf;

        void'($urandom(32'hd2c9_613c));
        reset      = 1'b1;
        cpu_req    = '0;
        hit        = '0;
        lru        = 1'b0;
        write_back = 1'b0;
        refill     = '0;
        pend_valid = 1'b0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset", '0, rdata);
        apply_cmd("reset idle", '0, '0, 1'b0, 1'b0, '0);

        // fill both ways of every set before any word access
        for (set = 0; set < `CD_SETS; set++) begin
            for (way = 0; way < `CD_WAYS; way++) begin
                rf.valid = 1'b1;
                rf.line  = random_line();
                apply_cmd("initial refill", make_req(1'b0, '0, set, 0, '0), '0, 1'(way),
                          1'b0, rf);
            end
        end

        for (int n = 0; n < NUM_READS; n++) begin
            way  = $urandom_range(1, 0);
            set  = $urandom_range(`CD_SETS - 1, 0);
            word = $urandom_range(`CD_LINE_WORDS - 1, 0);
            apply_cmd("read", make_req(1'b1, '0, set, word, $urandom),
                      way_mask_t'(1 << way), 1'($urandom), 1'b0, '0);
        end

        // the write returns the old word, the read right after it the merged one
        for (int n = 0; n < NUM_WRITES; n++) begin
            way  = $urandom_range(1, 0);
            set  = $urandom_range(`CD_SETS - 1, 0);
            word = $urandom_range(`CD_LINE_WORDS - 1, 0);
            we   = byte_en_t'($urandom_range(15, 1));
            apply_cmd("masked write", make_req(1'b1, we, set, word, $urandom),
                      way_mask_t'(1 << way), 1'($urandom), 1'b0, '0);
            apply_cmd("read after write", make_req(1'b1, '0, set, word, $urandom),
                      way_mask_t'(1 << way), 1'($urandom), 1'b0, '0);
        end

        for (int n = 0; n < NUM_NO_HIT; n++) begin
            way  = $urandom_range(1, 0);
            set  = $urandom_range(`CD_SETS - 1, 0);
            word = $urandom_range(`CD_LINE_WORDS - 1, 0);
            we   = byte_en_t'($urandom);
            apply_cmd("no hit", make_req(1'b1, we, set, word, $urandom), '0,
                      1'($urandom), 1'b0, '0);
            apply_cmd("read after no hit", make_req(1'b1, '0, set, word, $urandom),
                      way_mask_t'(1 << way), 1'($urandom), 1'b0, '0);
        end

        // a write request in the same cycle must lose to the line command
        for (int n = 0; n < NUM_WB; n++) begin
            set  = $urandom_range(`CD_SETS - 1, 0);
            word = $urandom_range(`CD_LINE_WORDS - 1, 0);
            l    = 1'($urandom);
            we   = byte_en_t'($urandom_range(15, 1));
            apply_cmd("write-back", make_req(1'b1, we, set, word, $urandom), '0, l,
                      1'b1, '0);
        end

        for (int n = 0; n < NUM_VICTIMS; n++) begin
            set      = $urandom_range(`CD_SETS - 1, 0);
            word     = $urandom_range(`CD_LINE_WORDS - 1, 0);
            l        = 1'($urandom);
            we       = byte_en_t'($urandom_range(15, 1));
            rf.valid = 1'b1;
            rf.line  = random_line();
            apply_cmd("refill victim", make_req(1'b1, we, set, word, $urandom), '0, l,
                      1'b0, rf);
            apply_cmd("read after refill", make_req(1'b1, '0, set, word, $urandom),
                      way_mask_t'(1 << l), 1'($urandom), 1'b0, '0);
        end

        apply_cmd("drain", '0, '0, 1'b0, 1'b0, '0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/cache_data_pkg.sv
design/data_bank.sv
design/data_way.sv
design/read_select.sv
design/cache_data_top.sv
bench/tb_cache_data.sv
